//--- logic/cache_params.svh
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// processor and memory address width, word granular
`define CACHE_ADDR_BITS 32
`define CACHE_WORD_BITS 32

// one block is one four-beat burst
`define CACHE_BLOCK_WORDS 4
`define CACHE_SETS 64

// address bits above index and word offset
`define CACHE_TAG_BITS 24

`endif

//--- logic/cache_types_pkg.sv
`default_nettype none

`include "cache_params.svh"

package cache_types_pkg;

	typedef logic [`CACHE_WORD_BITS-1:0] word_t;
	typedef logic [`CACHE_ADDR_BITS-1:0] addr_t;

	typedef logic [$clog2(`CACHE_SETS)-1:0] index_t;
	typedef logic [$clog2(`CACHE_BLOCK_WORDS)-1:0] offset_t; // word within block
	typedef logic [`CACHE_TAG_BITS-1:0] tag_t;

	// stored per way and per set
	typedef struct packed {
		logic valid;
		logic dirty; // block differs from memory
		tag_t tag;
	} tag_entry_t;

	// word 0 in the low bits
	typedef word_t [`CACHE_BLOCK_WORDS-1:0] block_t;

endpackage

`default_nettype wire

//--- logic/cache_ctrl_pkg.sv
`default_nettype none

`include "cache_params.svh"

package cache_ctrl_pkg;

	typedef enum logic [2:0] {
		IDLE,
		LOOKUP,
		WRITEBACK, // dirty victim goes out
		FILL, // new block comes in
		INSTALL
	} fsm_state_t;

	typedef logic [$clog2(`CACHE_BLOCK_WORDS)-1:0] beat_t;

endpackage

`default_nettype wire

//--- logic/set_ram.sv
`default_nettype none

`include "cache_params.svh"

// one way of the cache, tags or data depending on entry_t
module set_ram #(
	parameter type entry_t = logic
) (
	input logic clk,
	input logic reset,
	input cache_types_pkg::index_t index,
	input logic we,
	input entry_t wdata,
	output entry_t rdata
);

	entry_t mem [`CACHE_SETS];

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			for (int i = 0; i < `CACHE_SETS; i++) begin
				mem[i] <= '0; // no valid bits after reset
			end
		end else if (we) begin
			mem[index] <= wdata;
		end
	end

	assign rdata = mem[index]; // combinational read

endmodule

`default_nettype wire

//--- logic/way_select.sv
`default_nettype none

`include "cache_params.svh"

module way_select (
	input logic clk,
	input logic reset,
	input cache_types_pkg::index_t index,
	input cache_types_pkg::offset_t offset,
	input cache_types_pkg::tag_t req_tag,
	input cache_types_pkg::word_t req_word,
	input cache_types_pkg::tag_entry_t tag_0,
	input cache_types_pkg::tag_entry_t tag_1,
	input cache_types_pkg::block_t block_0,
	input cache_types_pkg::block_t block_1,
	input cache_types_pkg::block_t fill_block,
	input logic use_fill,
	input logic touch,
	output logic hit,
	output logic hit_way,
	output logic victim_way,
	output logic victim_dirty,
	output cache_types_pkg::tag_t victim_tag,
	output cache_types_pkg::word_t read_word,
	output cache_types_pkg::block_t merged_block
);

	logic [`CACHE_SETS-1:0] lru; // set bit means way 1 is least recently used
	logic hit_0;
	logic hit_1;
	logic sel_way;
	cache_types_pkg::tag_entry_t victim_entry;
	cache_types_pkg::block_t base_block;

	assign hit_0 = tag_0.valid && (tag_0.tag == req_tag);
	assign hit_1 = tag_1.valid && (tag_1.tag == req_tag);
	assign hit = hit_0 | hit_1;
	assign hit_way = hit_1;

	assign victim_way = lru[index];
	assign victim_entry = victim_way ? tag_1 : tag_0;
	assign victim_dirty = victim_entry.valid & victim_entry.dirty; // needs a writeback
	assign victim_tag = victim_entry.tag;

	// on a miss the victim block passes through, which feeds the evict register
	assign sel_way = hit ? hit_way : victim_way;
	assign base_block = use_fill ? fill_block : (sel_way ? block_1 : block_0);
	assign read_word = base_block[offset];

	always_comb begin
		merged_block = base_block;
		merged_block[offset] = req_word;
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			lru <= '0;
		end else if (touch) begin
			lru[index] <= ~hit_way; // other way becomes the victim
		end
	end

endmodule

`default_nettype wire

//--- logic/line_buffer.sv
`default_nettype none

`include "cache_params.svh"

module line_buffer (
	input logic clk,
	input logic reset,
	input logic beat,
	input logic load_evict,
	input cache_types_pkg::block_t evict_block,
	input cache_types_pkg::word_t rdata_mem,
	output cache_types_pkg::word_t wdata_mem,
	output cache_types_pkg::block_t fill_block,
	output logic burst_done
);

	cache_ctrl_pkg::beat_t count; // wraps back to 0 after the last beat
	cache_types_pkg::block_t evict_q;

	assign burst_done = beat && (count == cache_ctrl_pkg::beat_t'(`CACHE_BLOCK_WORDS - 1));
	assign wdata_mem = evict_q[0];

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			count <= '0;
		end else if (beat) begin
			count <= count + 1'b1;
		end
	end

	// read beats land in order, word 0 first
	always_ff @(posedge clk) begin
		if (beat) begin
			fill_block[count] <= rdata_mem;
		end
	end

	always_ff @(posedge clk) begin
		if (load_evict) begin
			evict_q <= evict_block;
		end else if (beat) begin
			evict_q <= evict_q >> `CACHE_WORD_BITS; // next word down to slot 0
		end
	end

endmodule

`default_nettype wire

//--- logic/cache_fsm.sv
`default_nettype none

module cache_fsm (
	input logic clk,
	input logic reset,
	input cache_types_pkg::addr_t addr_up,
	input cache_types_pkg::word_t wdata_up,
	input logic read_up,
	input logic write_up,
	output logic stall_up,
	output cache_types_pkg::word_t rdata_up,
	output cache_types_pkg::addr_t addr_mem,
	output logic read_mem,
	output logic write_mem,
	input logic ready_mem,
	input logic burst_done,
	input logic hit,
	input logic hit_way,
	input logic victim_way,
	input logic victim_dirty,
	input cache_types_pkg::tag_t victim_tag,
	input cache_types_pkg::word_t read_word,
	output cache_types_pkg::index_t index,
	output cache_types_pkg::offset_t offset,
	output cache_types_pkg::tag_t req_tag,
	output logic req_write,
	output cache_types_pkg::word_t req_word,
	output logic beat,
	output logic load_evict,
	output logic [1:0] tag_we,
	output logic [1:0] data_we,
	output cache_types_pkg::tag_entry_t install_tag,
	output logic use_fill,
	output logic touch
);

	cache_ctrl_pkg::fsm_state_t state;
	cache_types_pkg::addr_t req_addr;
	cache_types_pkg::word_t wdata_q;
	logic lookup_done;
	logic apply_write;

	assign {req_tag, index, offset} = req_addr;

	assign lookup_done = (state == cache_ctrl_pkg::LOOKUP) && hit;
	assign use_fill = (state == cache_ctrl_pkg::INSTALL);
	assign touch = lookup_done;
	assign load_evict = (state == cache_ctrl_pkg::LOOKUP) && !hit;
	assign beat = (read_mem | write_mem) & ready_mem;

	// otherwise the selected word is merged back onto itself and the block is unchanged
	assign apply_write = req_write && (lookup_done || use_fill);
	assign req_word = apply_write ? wdata_q : read_word;

	assign install_tag = '{valid: 1'b1, dirty: req_write, tag: req_tag};

	always_comb begin
		tag_we = '0;
		data_we = '0;
		if (lookup_done && req_write) begin
			tag_we[hit_way] = 1'b1;
			data_we[hit_way] = 1'b1;
		end else if (use_fill) begin
			tag_we[victim_way] = 1'b1;
			data_we[victim_way] = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if ((state == cache_ctrl_pkg::IDLE) && (read_up || write_up)) begin
			req_addr <= addr_up;
			wdata_q <= wdata_up;
		end
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state <= cache_ctrl_pkg::IDLE;
			req_write <= 1'b0;
			stall_up <= 1'b0;
			rdata_up <= '0;
			addr_mem <= '0;
			read_mem <= 1'b0;
			write_mem <= 1'b0;
		end else begin
			case (state)
				cache_ctrl_pkg::IDLE: begin
					if (read_up || write_up) begin
						req_write <= write_up;
						stall_up <= 1'b1;
						state <= cache_ctrl_pkg::LOOKUP;
					end
				end
				cache_ctrl_pkg::LOOKUP: begin
					if (hit) begin
						stall_up <= 1'b0;
						if (!req_write)
							rdata_up <= read_word;
						state <= cache_ctrl_pkg::IDLE;
					end else if (victim_dirty) begin
						write_mem <= 1'b1;
						addr_mem <= {victim_tag, index, cache_types_pkg::offset_t'(0)};
						state <= cache_ctrl_pkg::WRITEBACK;
					end else begin
						read_mem <= 1'b1;
						addr_mem <= {req_tag, index, cache_types_pkg::offset_t'(0)};
						state <= cache_ctrl_pkg::FILL;
					end
				end
				cache_ctrl_pkg::WRITEBACK: begin
					if (burst_done) begin // straight into the fill burst
						write_mem <= 1'b0;
						read_mem <= 1'b1;
						addr_mem <= {req_tag, index, cache_types_pkg::offset_t'(0)};
						state <= cache_ctrl_pkg::FILL;
					end
				end
				cache_ctrl_pkg::FILL: begin
					if (burst_done) begin
						read_mem <= 1'b0;
						state <= cache_ctrl_pkg::INSTALL;
					end
				end
				cache_ctrl_pkg::INSTALL: state <= cache_ctrl_pkg::LOOKUP; // lookup again, now a hit
				default: state <= cache_ctrl_pkg::IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- logic/cache_top.sv
`default_nettype none

module cache_top (
	input logic clk,
	input logic reset,
	input cache_types_pkg::addr_t addr_up,
	input cache_types_pkg::word_t wdata_up,
	input logic read_up,
	input logic write_up,
	output cache_types_pkg::word_t rdata_up,
	output logic stall_up,
	output cache_types_pkg::addr_t addr_mem,
	output logic read_mem,
	output logic write_mem,
	output cache_types_pkg::word_t wdata_mem,
	input cache_types_pkg::word_t rdata_mem,
	input logic ready_mem
);

	cache_types_pkg::index_t index;
	cache_types_pkg::offset_t offset;
	cache_types_pkg::tag_t req_tag;
	cache_types_pkg::tag_t victim_tag;
	cache_types_pkg::word_t req_word;
	cache_types_pkg::word_t read_word;
	cache_types_pkg::tag_entry_t tag_0;
	cache_types_pkg::tag_entry_t tag_1;
	cache_types_pkg::tag_entry_t install_tag;
	cache_types_pkg::block_t block_0;
	cache_types_pkg::block_t block_1;
	cache_types_pkg::block_t fill_block;
	cache_types_pkg::block_t merged_block; // victim block on a miss
	logic [1:0] tag_we;
	logic [1:0] data_we;
	logic req_write;
	logic beat;
	logic load_evict;
	logic use_fill;
	logic touch;
	logic hit;
	logic hit_way;
	logic victim_way;
	logic victim_dirty;
	logic burst_done;

	cache_fsm u_fsm (
		.clk, .reset, .addr_up, .wdata_up, .read_up, .write_up, .stall_up, .rdata_up,
		.addr_mem, .read_mem, .write_mem, .ready_mem, .burst_done, .hit, .hit_way,
		.victim_way, .victim_dirty, .victim_tag, .read_word, .index, .offset, .req_tag,
		.req_write, .req_word, .beat, .load_evict, .tag_we, .data_we, .install_tag,
		.use_fill, .touch
	);

	way_select u_way_select (
		.clk, .reset, .index, .offset, .req_tag, .req_word, .tag_0, .tag_1, .block_0,
		.block_1, .fill_block, .use_fill, .touch, .hit, .hit_way, .victim_way,
		.victim_dirty, .victim_tag, .read_word, .merged_block
	);

	line_buffer u_line_buffer (
		.clk, .reset, .beat, .load_evict, .evict_block(merged_block), .rdata_mem,
		.wdata_mem, .fill_block, .burst_done
	);

	set_ram #(.entry_t(cache_types_pkg::tag_entry_t)) tag_ram_0 (
		.clk, .reset, .index, .we(tag_we[0]), .wdata(install_tag), .rdata(tag_0)
	);

	set_ram #(.entry_t(cache_types_pkg::tag_entry_t)) tag_ram_1 (
		.clk, .reset, .index, .we(tag_we[1]), .wdata(install_tag), .rdata(tag_1)
	);

	set_ram #(.entry_t(cache_types_pkg::block_t)) data_ram_0 (
		.clk, .reset, .index, .we(data_we[0]), .wdata(merged_block), .rdata(block_0)
	);

	set_ram #(.entry_t(cache_types_pkg::block_t)) data_ram_1 (
		.clk, .reset, .index, .we(data_we[1]), .wdata(merged_block), .rdata(block_1)
	);

endmodule

`default_nettype wire

//--- verif/cache_assertions.sv
`default_nettype none

module cache_assertions (
	input logic clk,
	input logic reset,
	input logic read_up,
	input logic write_up,
	input logic stall_up,
	input cache_types_pkg::addr_t addr_mem,
	input logic read_mem,
	input logic write_mem,
	input logic ready_mem
);
	timeunit 1ns;
	timeprecision 1ps;

	int fail_count = 0; // assertion failures so far

	// a burst is a write-back or a fill, never both
	one_strobe: assert property (@(posedge clk) disable iff (!reset)
		!(read_mem && write_mem))
	else begin
		$error("read_mem and write_mem high together");
		fail_count++;
	end

	addr_hold: assert property (@(posedge clk) disable iff (!reset)
		(read_mem || write_mem) && !ready_mem |=> $stable(addr_mem))
	else begin
		$error("addr_mem moved while the burst was held off");
		fail_count++;
	end

	stall_after_accept: assert property (@(posedge clk) disable iff (!reset)
		!stall_up && (read_up || write_up) |=> stall_up)
	else begin
		$error("stall_up stayed low after an accepted request");
		fail_count++;
	end

endmodule

bind cache_top cache_assertions u_assertions (.*);

`default_nettype wire

//--- verif/cache_tb.sv
`default_nettype none

`include "cache_params.svh"

module cache_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int RANDOM_OPS = 400;
	localparam int MISS_OPS = 24;
	localparam int TOTAL_OPS = 2 + 2 + 6 + RANDOM_OPS + MISS_OPS;
	localparam int CYCLE_LIMIT = TOTAL_OPS * 40; // average operation is well under 40 cycles

	logic clk = 1'b0;
	logic reset;
	cache_types_pkg::addr_t addr_up;
	cache_types_pkg::word_t wdata_up;
	logic read_up;
	logic write_up;
	cache_types_pkg::word_t rdata_up;
	logic stall_up;
	cache_types_pkg::addr_t addr_mem;
	logic read_mem;
	logic write_mem;
	cache_types_pkg::word_t wdata_mem;
	cache_types_pkg::word_t rdata_mem = '0;
	logic ready_mem = 1'b0;

	integer seed = 32'h5c0f_df6c;
	int errors = 0;
	int checks = 0;
	int tests_run = 0;
	int tests_bad = 0;
	int cycle_count = 0;
	int beat_cnt = 0; // beat within the current burst
	int wb_beats = 0;
	logic heavy_pressure = 1'b0;
	cache_types_pkg::addr_t cur_addr = '0; // address of the request in flight
	cache_types_pkg::word_t mem_model [cache_types_pkg::addr_t];
	cache_types_pkg::word_t ref_mem [cache_types_pkg::addr_t]; // latest write per address

	cache_top DUT (
		.clk, .reset, .addr_up, .wdata_up, .read_up, .write_up, .rdata_up, .stall_up,
		.addr_mem, .read_mem, .write_mem, .wdata_mem, .rdata_mem, .ready_mem
	);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("timeout, the run went past %0d cycles", CYCLE_LIMIT);
			$display("tests failed");
			$finish;
		end
	end

	function automatic cache_types_pkg::addr_t make_addr(input int tag, input int index,
			input int offset);
		return {cache_types_pkg::tag_t'(tag), cache_types_pkg::index_t'(index),
			cache_types_pkg::offset_t'(offset)};
	endfunction

	// never written words hold their address xor a fixed pattern
	function automatic cache_types_pkg::word_t ref_value(input cache_types_pkg::addr_t a);
		if (ref_mem.exists(a))
			return ref_mem[a];
		return a ^ 32'hA5A5_0000;
	endfunction

	function automatic cache_types_pkg::word_t mem_value(input cache_types_pkg::addr_t a);
		if (mem_model.exists(a))
			return mem_model[a];
		return a ^ 32'hA5A5_0000;
	endfunction

	task automatic check_word(input string name, input cache_types_pkg::word_t got,
			input cache_types_pkg::word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_addr(input string name, input cache_types_pkg::addr_t got,
			input cache_types_pkg::addr_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	// memory port, beats seen with the values from before the edge
	always @(posedge clk) begin
		cache_types_pkg::addr_t beat_addr;
		cache_types_pkg::addr_t exp_base;
		logic last;
		beat_addr = addr_mem + cache_types_pkg::addr_t'(beat_cnt);
		exp_base = {cur_addr[`CACHE_ADDR_BITS-1:2], 2'b00};
		last = 1'b0;
		if (write_mem) // victim tag is chosen by the cache, index and offset are not
			exp_base[`CACHE_ADDR_BITS-1 -: `CACHE_TAG_BITS] =
				addr_mem[`CACHE_ADDR_BITS-1 -: `CACHE_TAG_BITS];
		if (reset && (read_mem || write_mem) && ready_mem) begin
			check_addr("addr_mem", addr_mem, exp_base);
			if (write_mem) begin
				check_word("wdata_mem", wdata_mem, ref_value(beat_addr));
				mem_model[beat_addr] = wdata_mem;
				wb_beats++;
			end
			last = (beat_cnt == `CACHE_BLOCK_WORDS - 1);
			beat_cnt = last ? 0 : beat_cnt + 1;
		end
		// ready only once the burst address is visible, so rdata_mem is right
		if ((read_mem || write_mem) && !last) begin
			ready_mem <= heavy_pressure ? ($random(seed) % 2 != 0) : ($random(seed) % 4 != 0);
			rdata_mem <= mem_value(addr_mem + cache_types_pkg::addr_t'(beat_cnt));
		end else begin
			ready_mem <= 1'b0;
		end
	end

	task automatic run_op(input logic is_write, input cache_types_pkg::addr_t addr,
			input cache_types_pkg::word_t data, output int stall_cycles);
		@(posedge clk);
		cur_addr <= addr;
		addr_up <= addr;
		wdata_up <= data;
		read_up <= !is_write;
		write_up <= is_write;
		@(posedge clk); // accepting edge
		read_up <= 1'b0;
		write_up <= 1'b0;
		stall_cycles = 0;
		@(negedge clk);
		while (stall_up) begin
			stall_cycles++;
			@(negedge clk);
		end
	endtask

	task automatic do_read(input cache_types_pkg::addr_t addr, output int stall_cycles);
		run_op(1'b0, addr, '0, stall_cycles);
		check_word("rdata_up", rdata_up, ref_value(addr));
	endtask

	task automatic do_write(input cache_types_pkg::addr_t addr,
			input cache_types_pkg::word_t data);
		int stall_cycles;
		ref_mem[addr] = data;
		run_op(1'b1, addr, data, stall_cycles);
	endtask

	task automatic finish_test(input string name, input int start);
		tests_run++;
		if (errors == start) begin
			$display("%s: ok", name);
		end else begin
			tests_bad++;
			$display("%s: %0d errors", name, errors - start);
		end
	endtask

	initial begin
		int stall_cycles;
		int start;
		int wb_start;
		cache_types_pkg::addr_t a;
		reset = 1'b0;
		addr_up = '0;
		wdata_up = '0;
		read_up = 1'b0;
		write_up = 1'b0;
		repeat (2) @(posedge clk);
		reset <= 1'b1;
		@(negedge clk);

		start = errors;
		check_bit("stall_up", stall_up, 1'b0);
		check_bit("read_mem", read_mem, 1'b0);
		check_bit("write_mem", write_mem, 1'b0);
		check_word("rdata_up", rdata_up, '0);
		finish_test("reset state", start);

		start = errors;
		a = make_addr(0, 0, 1);
		do_read(a, stall_cycles);
		do_read(a, stall_cycles);
		checks++;
		if (stall_cycles != 1) begin
			errors++;
			$display("read of a cached address stalled %0d cycles instead of one", stall_cycles);
		end
		finish_test("read miss then hit", start);

		start = errors;
		a = make_addr(1, 0, 2);
		do_write(a, 32'hCAFE_0001);
		do_read(a, stall_cycles);
		finish_test("write then read", start);

		// three tags on one index, the third write pushes out a dirty block
		start = errors;
		wb_start = wb_beats;
		for (int t = 0; t < 3; t++)
			do_write(make_addr(t, 1, t), 32'h0BAD_0000 + t);
		checks++;
		if (wb_beats - wb_start < `CACHE_BLOCK_WORDS) begin
			errors++;
			$display("no write-back burst seen while evicting a dirty block");
		end
		for (int t = 0; t < 3; t++)
			do_read(make_addr(t, 1, t), stall_cycles);
		finish_test("dirty eviction", start);

		start = errors;
		for (int i = 0; i < RANDOM_OPS; i++) begin
			a = make_addr($random(seed) & 3, $random(seed) & 3, $random(seed) & 3);
			if ($random(seed) % 2 != 0)
				do_write(a, $random(seed));
			else
				do_read(a, stall_cycles);
		end
		finish_test("random reads and writes", start);

		// four tags round robin on two ways, so reads keep missing
		start = errors;
		heavy_pressure = 1'b1;
		for (int i = 0; i < MISS_OPS; i++)
			do_read(make_addr(i % 4, (i / 8) % 4, (i / 2) % 4), stall_cycles);
		heavy_pressure = 1'b0;
		finish_test("read misses under back-pressure", start);

		if (DUT.u_assertions.fail_count != 0) begin
			errors += DUT.u_assertions.fail_count;
			$display("bound assertions fired %0d times", DUT.u_assertions.fail_count);
		end
		$display("tests run %0d, with errors %0d, checks %0d, errors %0d",
			tests_run, tests_bad, checks, errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+logic
logic/cache_types_pkg.sv
logic/cache_ctrl_pkg.sv
logic/set_ram.sv
logic/way_select.sv
logic/line_buffer.sv
logic/cache_fsm.sv
logic/cache_top.sv
verif/cache_assertions.sv
verif/cache_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= cache_tb
FILELIST ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
SIM_ARGS ?= +verilator+error+limit+1000
PASS_TEXT ?= all tests passed

SOURCES := $(FILELIST) $(wildcard logic/*.sv logic/*.svh verif/*.sv)
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN) $(SIM_ARGS))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
